// ==== tb.f ====
id_pkg.sv
id_decoder.sv
id_operand_sel.sv
id_regfile.sv
id_ctrl_fsm.sv
id_ex_pipe.sv
id_stage.sv
tb_id_assertions.sv
tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - id_pkg.sv
  - id_decoder.sv
  - id_operand_sel.sv
  - id_regfile.sv
  - id_ctrl_fsm.sv
  - id_ex_pipe.sv
  - id_stage.sv
  - target: test
    files:
      - tb_id_assertions.sv
      - tb_id_stage.sv

// ==== tb_id_stage.sv ====
// Testbench for the RV32I decode stage
// Random instruction stream from an LFSR, reference decode with forwarding,
// scoreboard on the ID/EX handshake and a model of fetch_ready_o

module tb_id_stage;

  timeunit 1ns;
  timeprecision 1ps;

  import id_pkg::*;

  localparam int unsigned NUM_REGS  = 32;
  localparam int unsigned NUM_INSTR = 400;
  // Reset, four cycles per instruction, plus slack
  localparam int unsigned TIMEOUT   = 16 + 4 * NUM_INSTR + 200;

  logic       clk;
  logic       rst_n;
  logic       fetch_enable_i;
  logic       fetch_valid_i;
  fetch_t     fetch_i;
  logic       fetch_ready_o;
  reg_write_t wb_i;
  reg_write_t ex_fwd_i;
  logic       ex_valid_o;
  id_ex_t     ex_o;
  logic       ex_ready_i;

  // Scoreboard and model state
  logic [31:0] lfsr_q;
  word_t       model_regs [NUM_REGS];
  id_ex_t      exp_q [$];
  fsm_state_e  model_st;
  logic        accept_now;
  logic        latency_due;
  int unsigned accepted;
  int unsigned run_cycles;
  int unsigned cycles;

  id_stage #(
    .NUM_REGS ( NUM_REGS )
  ) i_id_stage (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .fetch_enable_i ( fetch_enable_i ),
    .fetch_valid_i  ( fetch_valid_i  ),
    .fetch_i        ( fetch_i        ),
    .fetch_ready_o  ( fetch_ready_o  ),
    .wb_i           ( wb_i           ),
    .ex_fwd_i       ( ex_fwd_i       ),
    .ex_valid_o     ( ex_valid_o     ),
    .ex_o           ( ex_o           ),
    .ex_ready_i     ( ex_ready_i     )
  );

  //////////////////////////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Registers x0..x3 only, so hazards and forwards hit often
  function automatic reg_addr_t rand_reg();
    return reg_addr_t'(rand_bits(2));
  endfunction

  function automatic word_t make_instr();
    logic [3:0] group;
    group = 4'(rand_bits(4));
    case (group)
      4'd0, 4'd1:
        return {rand_bits(1) ? 7'h20 : 7'h00, rand_reg(), rand_reg(), 3'(rand_bits(3)),
                rand_reg(), 7'b0110011};
      4'd2:  return {12'(rand_bits(12)), rand_reg(), 3'(rand_bits(3)), rand_reg(), 7'b0010011};
      4'd3:  return {20'(rand_bits(20)), rand_reg(), 7'b0110111};
      4'd4:  return {20'(rand_bits(20)), rand_reg(), 7'b0010111};
      4'd5:  return {20'(rand_bits(20)), rand_reg(), 7'b1101111};
      4'd6:  return {12'(rand_bits(12)), rand_reg(), 3'b000, rand_reg(), 7'b1100111};
      4'd7, 4'd8:
        return {7'(rand_bits(7)), rand_reg(), rand_reg(), 3'(rand_bits(3)),
                5'(rand_bits(5)), 7'b1100011};
      4'd9, 4'd10, 4'd11:
        return {12'(rand_bits(12)), rand_reg(), 3'(rand_bits(3)), rand_reg(), 7'b0000011};
      4'd12, 4'd13:
        return {7'(rand_bits(7)), rand_reg(), rand_reg(), 3'(rand_bits(3)),
                5'(rand_bits(5)), 7'b0100011};
      // Mostly unknown opcodes
      default: return rand_bits(32);
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic word_t src_value(reg_addr_t addr, reg_write_t exf, reg_write_t wbw);
    if (addr == 0)
      return '0;
    if (exf.we && exf.addr == addr)
      return exf.data;
    if (wbw.we && wbw.addr == addr)
      return wbw.data;
    return (addr < NUM_REGS) ? model_regs[addr] : '0;
  endfunction

  function automatic alu_op_e alu_from_funct(logic [2:0] f3, logic alt);
    alu_op_e ops [8];
    ops = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    if (alt && f3 == 3'b000)
      return ALU_SUB;
    if (alt && f3 == 3'b101)
      return ALU_SRA;
    return ops[f3];
  endfunction

  // Expected payload, plus the source registers the stage reports
  function automatic id_ex_t ref_payload(fetch_t f, reg_write_t exf, reg_write_t wbw,
                                         output reg_addr_t rs1, output reg_addr_t rs2);
    id_ex_t     p;
    word_t      in;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       bad;
    logic       use1;
    logic       use2;
    in    = f.instr;
    f3    = in[14:12];
    f7    = in[31:25];
    imm_i = word_t'($signed(in[31:20]));
    imm_s = word_t'($signed({in[31:25], in[11:7]}));
    imm_b = word_t'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
    imm_u = {in[31:12], 12'h0};
    imm_j = word_t'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
    p = '0;
    p.alu_op = ALU_ADD;
    p.mem_op = MEM_NONE;
    p.jump   = JMP_NONE;
    bad  = 1'b0;
    use1 = 1'b0;
    use2 = 1'b0;
    case (in[6:0])
      7'b0110011:
      begin
        use1     = 1'b1;
        use2     = 1'b1;
        p.rd_we  = 1'b1;
        p.alu_op = alu_from_funct(f3, f7[5]);
        bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
      end
      7'b0010011:
      begin
        use1     = 1'b1;
        p.rd_we  = 1'b1;
        p.alu_op = alu_from_funct(f3, f3 == 3'b101 && f7[5]);
        if (f3 == 3'b001)
          bad = (f7 != 7'h00);
        if (f3 == 3'b101)
          bad = (f7 != 7'h00 && f7 != 7'h20);
      end
      7'b0110111, 7'b0010111, 7'b1101111: p.rd_we = 1'b1;
      7'b1100111:
      begin
        use1    = 1'b1;
        p.rd_we = 1'b1;
        bad     = (f3 != 3'b000);
      end
      7'b1100011:
      begin
        use1 = 1'b1;
        use2 = 1'b1;
        case (f3)
          3'b000:  p.alu_op = ALU_EQ;
          3'b001:  p.alu_op = ALU_NE;
          3'b100:  p.alu_op = ALU_LT;
          3'b101:  p.alu_op = ALU_GE;
          3'b110:  p.alu_op = ALU_LTU;
          3'b111:  p.alu_op = ALU_GEU;
          default: bad = 1'b1;
        endcase
      end
      7'b0000011:
      begin
        use1    = 1'b1;
        p.rd_we = 1'b1;
        p.mem_op = MEM_LOAD;
        bad = (f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111);
      end
      7'b0100011:
      begin
        use1     = 1'b1;
        use2     = 1'b1;
        p.mem_op = MEM_STORE;
        bad = f3[2] || f3[1:0] == 2'b11;
      end
      default: bad = 1'b1;
    endcase
    rs1 = use1 ? in[19:15] : '0;
    rs2 = use2 ? in[24:20] : '0;
    if (p.mem_op != MEM_NONE)
    begin
      p.mem_size   = f3[1:0];
      p.mem_signed = !f3[2];
    end
    // Per-group operands and target
    case (in[6:0])
      7'b0110011, 7'b1100011:
      begin
        p.operand_a = src_value(rs1, exf, wbw);
        p.operand_b = src_value(rs2, exf, wbw);
      end
      7'b0010011, 7'b0000011:
      begin
        p.operand_a = src_value(rs1, exf, wbw);
        p.operand_b = imm_i;
      end
      7'b0100011:
      begin
        p.operand_a = src_value(rs1, exf, wbw);
        p.operand_b = imm_s;
      end
      7'b0110111: p.operand_b = imm_u;
      7'b0010111:
      begin
        p.operand_a = f.pc;
        p.operand_b = imm_u;
      end
      default:
      begin
        p.operand_a = f.pc;
        p.operand_b = 32'd4;
      end
    endcase
    if (in[6:0] == 7'b1101111)
    begin
      p.jump        = JMP_JAL;
      p.jump_target = f.pc + imm_j;
    end
    if (in[6:0] == 7'b1100111)
    begin
      p.jump        = JMP_JALR;
      p.jump_target = src_value(rs1, exf, wbw) + imm_i;
    end
    if (in[6:0] == 7'b1100011)
    begin
      p.jump        = JMP_BRANCH;
      p.jump_target = f.pc + imm_b;
    end
    // Illegal word is an empty bubble
    if (bad)
    begin
      p         = '0;
      p.alu_op  = ALU_NOP;
      p.illegal = 1'b1;
      rs1       = '0;
      rs2       = '0;
    end
    p.pc         = f.pc;
    p.rd         = in[11:7];
    p.store_data = src_value(rs2, exf, wbw);
    return p;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_payload(string name, id_ex_t exp, id_ex_t act);
    if (act !== exp)
      abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (act !== exp)
      abort_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp)
      abort_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
  endtask

  // Clock
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Timeout guard
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > TIMEOUT)
      abort_run($sformatf("Timeout, run not finished after %0d cycles", cycles));
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus, driven at the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      run_cycles++;
      // Enable late, and drop it once for a while
      fetch_enable_i <= (run_cycles >= 20) && !(run_cycles >= 300 && run_cycles < 312);
      // Fetch holds its word until accepted
      if (!fetch_valid_i || accept_now)
      begin
        if (accepted < NUM_INSTR)
        begin
          fetch_valid_i <= (rand_bits(2) != 0);
          fetch_i.instr <= make_instr();
          fetch_i.pc    <= {rand_bits(30), 2'b00};
        end
        else
          fetch_valid_i <= 1'b0;
      end
      ex_ready_i    <= (rand_bits(2) != 0);
      wb_i.we       <= rand_bits(1);
      wb_i.addr     <= rand_reg();
      wb_i.data     <= rand_bits(32);
      ex_fwd_i.we   <= (rand_bits(2) == 0);
      ex_fwd_i.addr <= rand_reg();
      ex_fwd_i.data <= rand_bits(32);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare, at the falling edge where everything is settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    id_ex_t    exp;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      hazard;
    logic      exp_rdy;
    // Bound protocol properties
    if (i_id_stage.i_assertions.fail_cnt != 0)
      abort_run("Protocol assertion failed inside id_stage");
    if (!rst_n)
    begin
      model_st = ST_BOOT;
      check_ready("reset ready", 1'b0, fetch_ready_o);
      check_valid("reset valid", 1'b0, ex_valid_o);
    end
    else
    begin
      if (latency_due)
      begin
        check_valid("latency valid", 1'b1, ex_valid_o);
        check_payload("latency payload", exp_q[$], ex_o);
      end
      check_valid("ex valid", exp_q.size() != 0, ex_valid_o);
      exp = ref_payload(fetch_i, ex_fwd_i, wb_i, rs1, rs2);
      // Load-use against the entry held in ID/EX
      hazard = exp_q.size() != 0 && exp_q[0].mem_op == MEM_LOAD && exp_q[0].rd != 0 &&
               (exp_q[0].rd == rs1 || exp_q[0].rd == rs2);
      exp_rdy = model_st == ST_RUN && (exp_q.size() == 0 || ex_ready_i) && !hazard;
      check_ready("fetch ready", exp_rdy, fetch_ready_o);
      if (exp_q.size() != 0 && ex_ready_i)
      begin
        check_payload("transfer", exp_q[0], ex_o);
        void'(exp_q.pop_front());
      end
      accept_now = fetch_valid_i && exp_rdy;
      if (accept_now)
      begin
        exp_q.push_back(exp);
        accepted++;
      end
      latency_due = accept_now;
      // Writeback lands at the coming edge
      if (wb_i.we && wb_i.addr != 0 && wb_i.addr < NUM_REGS)
        model_regs[wb_i.addr] = wb_i.data;
      case (model_st)
        ST_BOOT: model_st = ST_IDLE;
        ST_IDLE: model_st = fetch_enable_i ? ST_RUN : ST_IDLE;
        default: model_st = fetch_enable_i ? ST_RUN : ST_IDLE;
      endcase
    end
  end

  // Reset, then wait for the stream to drain
  initial
  begin
    lfsr_q         = 32'h2d50;
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_i        = '{instr: 32'h0000_0013, pc: '0};
    wb_i           = '0;
    ex_fwd_i       = '0;
    ex_ready_i     = 1'b0;
    model_st       = ST_BOOT;
    accept_now     = 1'b0;
    latency_due    = 1'b0;
    accepted       = 0;
    run_cycles     = 0;
    cycles         = 0;
    foreach (model_regs[i])
      model_regs[i] = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    while (!(accepted == NUM_INSTR && exp_q.size() == 0))
      @(negedge clk);
    @(negedge clk);
    if (i_id_stage.i_assertions.fail_cnt == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
      abort_run("Protocol assertion failed inside id_stage");
  end

endmodule

// ==== tb_id_assertions.sv ====
// Protocol assertions for the decode stage
// Bound into every id_stage instance

module tb_id_assertions (
  input logic           clk,
  input logic           rst_n,
  input logic           fetch_valid_i,
  input logic           fetch_ready_o,
  input logic           ex_valid_o,
  input id_pkg::id_ex_t ex_o,
  input logic           ex_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failed properties so far
  int unsigned fail_cnt = 0;

  // Stalled payload holds
  assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && !ex_ready_i |=> ex_valid_o && $stable(ex_o))
    else
    begin
      fail_cnt++;
      $error("ex_o changed while stalled");
    end

  // Quiet during reset
  assert property (@(posedge clk) !rst_n |-> !fetch_ready_o && !ex_valid_o)
    else
    begin
      fail_cnt++;
      $error("Handshake active in reset");
    end

  // One-cycle latency
  assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_i && fetch_ready_o |=> ex_valid_o)
    else
    begin
      fail_cnt++;
      $error("Accepted instruction missing on ex_o");
    end

endmodule

bind id_stage tb_id_assertions i_assertions (
  .clk           ( clk           ),
  .rst_n         ( rst_n         ),
  .fetch_valid_i ( fetch_valid_i ),
  .fetch_ready_o ( fetch_ready_o ),
  .ex_valid_o    ( ex_valid_o    ),
  .ex_o          ( ex_o          ),
  .ex_ready_i    ( ex_ready_i    )
);

// ==== id_stage.sv ====
// Decode stage of a small in-order RV32I core
// Fetch in over valid/ready, register read with EX/WB forwarding,
// payload out to EX through the ID/EX register

module id_stage #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_enable_i,
  input  logic               fetch_valid_i,
  input  id_pkg::fetch_t     fetch_i,
  output logic               fetch_ready_o,
  input  id_pkg::reg_write_t wb_i,
  input  id_pkg::reg_write_t ex_fwd_i,
  output logic               ex_valid_o,
  output id_pkg::id_ex_t     ex_o,
  input  logic               ex_ready_i
);

  import id_pkg::*;

  dec_ctrl_t dec_ctrl;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     rdata_a;
  word_t     rdata_b;
  id_ex_t    id_payload;
  logic      pipe_ready;
  logic      pipe_load;

  // Accepting edge
  assign pipe_load = fetch_valid_i && fetch_ready_o;

  id_decoder i_decoder (
    .fetch_i ( fetch_i  ),
    .ctrl_o  ( dec_ctrl ),
    .rs1_o   ( rs1      ),
    .rs2_o   ( rs2      ),
    .rd_o    ( rd       )
  );

  id_regfile #(
    .NUM_REGS ( NUM_REGS )
  ) i_regfile (
    .clk       ( clk     ),
    .rst_n     ( rst_n   ),
    .raddr_a_i ( rs1     ),
    .raddr_b_i ( rs2     ),
    .rdata_a_o ( rdata_a ),
    .rdata_b_o ( rdata_b ),
    .wr_i      ( wb_i    )
  );

  id_operand_sel i_operand_sel (
    .fetch_i   ( fetch_i    ),
    .ctrl_i    ( dec_ctrl   ),
    .rs1_i     ( rs1        ),
    .rs2_i     ( rs2        ),
    .rd_i      ( rd         ),
    .rdata_a_i ( rdata_a    ),
    .rdata_b_i ( rdata_b    ),
    .ex_fwd_i  ( ex_fwd_i   ),
    .wb_i      ( wb_i       ),
    .payload_o ( id_payload )
  );

  id_ctrl_fsm i_ctrl_fsm (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .fetch_enable_i ( fetch_enable_i ),
    .rs1_i          ( rs1            ),
    .rs2_i          ( rs2            ),
    .ex_valid_i     ( ex_valid_o     ),
    .ex_payload_i   ( ex_o           ),
    .pipe_ready_i   ( pipe_ready     ),
    .accept_o       ( fetch_ready_o  )
  );

  id_ex_pipe i_ex_pipe (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .load_i       ( pipe_load  ),
    .payload_i    ( id_payload ),
    .ex_ready_i   ( ex_ready_i ),
    .ex_valid_o   ( ex_valid_o ),
    .ex_o         ( ex_o       ),
    .pipe_ready_o ( pipe_ready )
  );

endmodule

// ==== id_ex_pipe.sv ====
// ID/EX pipeline register
// One entry with a valid bit and valid/ready back-pressure toward EX

module id_ex_pipe (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load_i,
  input  id_pkg::id_ex_t payload_i,
  input  logic           ex_ready_i,
  output logic           ex_valid_o,
  output id_pkg::id_ex_t ex_o,
  output logic           pipe_ready_o
);

  import id_pkg::*;

  logic   valid_q;
  id_ex_t payload_q;

  // Free, or draining this cycle
  assign pipe_ready_o = !valid_q || ex_ready_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else if (load_i)
      valid_q <= 1'b1;
    else if (ex_ready_i)
      valid_q <= 1'b0;
  end

  // Payload only moves on a load
  always_ff @(posedge clk)
  begin
    if (load_i)
      payload_q <= payload_i;
  end

  assign ex_valid_o = valid_q;
  assign ex_o       = payload_q;

endmodule

// ==== id_ctrl_fsm.sv ====
// Decode control FSM
// Boot cycle after reset, idle until fetch enable, then run
// Holds off fetch on a load-use hazard against the ID/EX entry

module id_ctrl_fsm (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              fetch_enable_i,
  input  id_pkg::reg_addr_t rs1_i,
  input  id_pkg::reg_addr_t rs2_i,
  input  logic              ex_valid_i,
  input  id_pkg::id_ex_t    ex_payload_i,
  input  logic              pipe_ready_i,
  output logic              accept_o
);

  import id_pkg::*;

  fsm_state_e state_q;
  fsm_state_e state_d;
  logic       load_in_ex;
  logic       load_use;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      // Single boot cycle
      ST_BOOT: state_d = ST_IDLE;
      ST_IDLE:
      begin
        if (fetch_enable_i)
          state_d = ST_RUN;
      end
      ST_RUN:
      begin
        if (!fetch_enable_i)
          state_d = ST_IDLE;
      end
      default: state_d = ST_BOOT;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_BOOT;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////////////////////////
  // Load-use hazard
  //////////////////////////////////////////////////////////////////////

  // Load in ID/EX with a real destination
  assign load_in_ex = ex_valid_i && (ex_payload_i.mem_op == MEM_LOAD) &&
                      (ex_payload_i.rd != '0);
  // Held until the load transfers to EX
  assign load_use   = load_in_ex &&
                      ((ex_payload_i.rd == rs1_i) || (ex_payload_i.rd == rs2_i));

  assign accept_o = (state_q == ST_RUN) && pipe_ready_i && !load_use;

endmodule

// ==== id_regfile.sv ====
// Integer register file, two read ports and one write port
// x0 is hard-wired to zero, addresses at or above NUM_REGS read zero

module id_regfile #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  id_pkg::reg_addr_t  raddr_a_i,
  input  id_pkg::reg_addr_t  raddr_b_i,
  output id_pkg::word_t      rdata_a_o,
  output id_pkg::word_t      rdata_b_o,
  input  id_pkg::reg_write_t wr_i
);

  import id_pkg::*;

  // No storage for x0
  word_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < NUM_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (wr_i.we)
    begin
      for (int i = 1; i < NUM_REGS; i++)
      begin
        if (wr_i.addr == REG_ADDR_W'(i))
          regs_q[i] <= wr_i.data;
      end
    end
  end

  // Read ports, zero when no register matches
  always_comb
  begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    for (int i = 1; i < NUM_REGS; i++)
    begin
      if (raddr_a_i == REG_ADDR_W'(i))
        rdata_a_o = regs_q[i];
      if (raddr_b_i == REG_ADDR_W'(i))
        rdata_b_o = regs_q[i];
    end
  end

endmodule

// ==== id_operand_sel.sv ====
// Operand selection of the decode stage
// Builds immediates, forwards EX and WB results, muxes operands
// and jump target, and assembles the ID/EX payload

module id_operand_sel (
  input  id_pkg::fetch_t     fetch_i,
  input  id_pkg::dec_ctrl_t  ctrl_i,
  input  id_pkg::reg_addr_t  rs1_i,
  input  id_pkg::reg_addr_t  rs2_i,
  input  id_pkg::reg_addr_t  rd_i,
  input  id_pkg::word_t      rdata_a_i,
  input  id_pkg::word_t      rdata_b_i,
  input  id_pkg::reg_write_t ex_fwd_i,
  input  id_pkg::reg_write_t wb_i,
  output id_pkg::id_ex_t     payload_o
);

  import id_pkg::*;

  word_t instr;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t imm;
  word_t rs1_val;
  word_t rs2_val;
  word_t operand_a;
  word_t operand_b;
  word_t jump_target;

  // x0, then EX, then WB, then register file
  function automatic word_t fwd_value(reg_addr_t addr, word_t rf_data,
                                      reg_write_t ex_fwd, reg_write_t wb);
    word_t value;
    if (addr == '0)
      value = '0;
    else if (ex_fwd.we && (ex_fwd.addr == addr))
      value = ex_fwd.data;
    else if (wb.we && (wb.addr == addr))
      value = wb.data;
    else
      value = rf_data;
    return value;
  endfunction

  assign instr = fetch_i.instr;

  //////////////////////////////////////////////////////////////////////
  // Immediates, sign extended from bit 31
  //////////////////////////////////////////////////////////////////////

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb
  begin
    case (ctrl_i.imm_sel)
      IMM_S:   imm = imm_s;
      IMM_B:   imm = imm_b;
      IMM_U:   imm = imm_u;
      IMM_J:   imm = imm_j;
      default: imm = imm_i;
    endcase
  end

  // Forwarded source values
  assign rs1_val = fwd_value(rs1_i, rdata_a_i, ex_fwd_i, wb_i);
  assign rs2_val = fwd_value(rs2_i, rdata_b_i, ex_fwd_i, wb_i);

  //////////////////////////////////////////////////////////////////////
  // Operand and target muxes
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (ctrl_i.op_a_sel)
      OPA_REG: operand_a = rs1_val;
      OPA_PC:  operand_a = fetch_i.pc;
      default: operand_a = '0;
    endcase

    case (ctrl_i.op_b_sel)
      OPB_IMM:  operand_b = imm;
      OPB_LINK: operand_b = XLEN'(4);
      default:  operand_b = rs2_val;
    endcase

    // JALR target uses the forwarded rs1, imm follows the jump kind
    case (ctrl_i.jump)
      JMP_JAL:    jump_target = fetch_i.pc + imm;
      JMP_JALR:   jump_target = rs1_val + imm;
      JMP_BRANCH: jump_target = fetch_i.pc + imm;
      default:    jump_target = '0;
    endcase
  end

  // Payload to ID/EX
  always_comb
  begin
    payload_o.pc          = fetch_i.pc;
    payload_o.operand_a   = operand_a;
    payload_o.operand_b   = operand_b;
    payload_o.store_data  = rs2_val;
    payload_o.jump_target = jump_target;
    payload_o.rd          = rd_i;
    payload_o.rd_we       = ctrl_i.rd_we;
    payload_o.alu_op      = ctrl_i.alu_op;
    payload_o.mem_op      = ctrl_i.mem_op;
    payload_o.mem_size    = ctrl_i.mem_size;
    payload_o.mem_signed  = ctrl_i.mem_signed;
    payload_o.jump        = ctrl_i.jump;
    payload_o.illegal     = ctrl_i.illegal;
  end

endmodule

// ==== id_decoder.sv ====
// RV32I instruction decoder
// Maps opcode and funct fields onto the control struct and register addresses
// Unknown encodings decode to a bubble with the illegal flag set

module id_decoder (
  input  id_pkg::fetch_t    fetch_i,
  output id_pkg::dec_ctrl_t ctrl_o,
  output id_pkg::reg_addr_t rs1_o,
  output id_pkg::reg_addr_t rs2_o,
  output id_pkg::reg_addr_t rd_o
);

  import id_pkg::*;

  // Default controls, also the illegal bubble
  localparam dec_ctrl_t CTRL_BUBBLE = '{
    alu_op:     ALU_NOP,
    op_a_sel:   OPA_ZERO,
    op_b_sel:   OPB_REG,
    imm_sel:    IMM_I,
    mem_op:     MEM_NONE,
    mem_size:   2'b00,
    mem_signed: 1'b0,
    jump:       JMP_NONE,
    rd_we:      1'b0,
    illegal:    1'b0
  };

  word_t      instr;
  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  dec_ctrl_t  ctrl;
  logic       use_rs1;
  logic       use_rs2;
  logic       illegal;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic alu_op_e arith_op(logic [2:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign instr  = fetch_i.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    ctrl    = CTRL_BUBBLE;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    illegal = 1'b0;

    case (opcode)
      OPC_OP:
      begin
        ctrl.alu_op   = arith_op(funct3, funct7[5]);
        ctrl.op_a_sel = OPA_REG;
        ctrl.rd_we    = 1'b1;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        // funct7 bit 5 only legal for SUB and SRA
        illegal = !(funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OPC_OP_IMM:
      begin
        // ADDI never subtracts, only SRAI uses bit 30
        ctrl.alu_op   = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
        ctrl.op_a_sel = OPA_REG;
        ctrl.op_b_sel = OPB_IMM;
        ctrl.rd_we    = 1'b1;
        use_rs1       = 1'b1;
        if (funct3 == 3'b001)
          illegal = (funct7 != 7'b0000000);
        else if (funct3 == 3'b101)
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      OPC_LUI, OPC_AUIPC:
      begin
        ctrl.alu_op   = ALU_ADD;
        ctrl.op_a_sel = (opcode == OPC_LUI) ? OPA_ZERO : OPA_PC;
        ctrl.op_b_sel = OPB_IMM;
        ctrl.imm_sel  = IMM_U;
        ctrl.rd_we    = 1'b1;
      end
      OPC_JAL, OPC_JALR:
      begin
        // Link value pc + 4 computed in EX
        ctrl.alu_op   = ALU_ADD;
        ctrl.op_a_sel = OPA_PC;
        ctrl.op_b_sel = OPB_LINK;
        ctrl.imm_sel  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        ctrl.jump     = (opcode == OPC_JAL) ? JMP_JAL : JMP_JALR;
        ctrl.rd_we    = 1'b1;
        use_rs1       = (opcode == OPC_JALR);
        illegal       = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH:
      begin
        ctrl.op_a_sel = OPA_REG;
        ctrl.imm_sel  = IMM_B;
        ctrl.jump     = JMP_BRANCH;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD, OPC_STORE:
      begin
        // Address is rs1 + offset
        ctrl.alu_op     = ALU_ADD;
        ctrl.op_a_sel   = OPA_REG;
        ctrl.op_b_sel   = OPB_IMM;
        ctrl.mem_size   = funct3[1:0];
        ctrl.mem_signed = ~funct3[2];
        use_rs1         = 1'b1;
        if (opcode == OPC_LOAD)
        begin
          ctrl.mem_op = MEM_LOAD;
          ctrl.rd_we  = 1'b1;
          // LB LH LW LBU LHU only
          illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
        end
        else
        begin
          ctrl.mem_op  = MEM_STORE;
          ctrl.imm_sel = IMM_S;
          use_rs2      = 1'b1;
          illegal      = funct3[2] || (funct3[1:0] == 2'b11);
        end
      end
      default: illegal = 1'b1;
    endcase

    // Bubble that reads and writes nothing
    if (illegal)
    begin
      ctrl         = CTRL_BUBBLE;
      ctrl.illegal = 1'b1;
      use_rs1      = 1'b0;
      use_rs2      = 1'b0;
    end
  end

  assign ctrl_o = ctrl;
  // Unused sources read as x0, no false hazard
  assign rs1_o  = use_rs1 ? instr[19:15] : '0;
  assign rs2_o  = use_rs2 ? instr[24:20] : '0;
  assign rd_o   = instr[11:7];

endmodule

// ==== id_pkg.sv ====
// Shared definitions of the RV32I decode stage
// Widths, opcode and control enums, and the packed structs on every bus

package id_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // Arithmetic ops first, then branch compares
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
    ALU_NOP
  } alu_op_e;

  typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;
  typedef enum logic [1:0] {JMP_NONE, JMP_JAL, JMP_JALR, JMP_BRANCH} jump_e;

  // Operand sources
  typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OPB_REG, OPB_IMM, OPB_LINK} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  // Control FSM
  typedef enum logic [1:0] {ST_BOOT, ST_IDLE, ST_RUN} fsm_state_e;

  // Register write, used by writeback and by the EX forward path
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } reg_write_t;

  // Fetch payload
  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_t;

  // Decoder controls
  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    imm_sel_e  imm_sel;
    mem_op_e   mem_op;
    logic [1:0] mem_size;
    logic      mem_signed;
    jump_e     jump;
    logic      rd_we;
    logic      illegal;
  } dec_ctrl_t;

  // ID/EX payload
  typedef struct packed {
    word_t     pc;
    word_t     operand_a;
    word_t     operand_b;
    word_t     store_data;
    word_t     jump_target;
    reg_addr_t rd;
    logic      rd_we;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    logic [1:0] mem_size;
    logic      mem_signed;
    jump_e     jump;
    logic      illegal;
  } id_ex_t;

endpackage
